//--- icache.f
rtl/icache_config_pkg.sv
rtl/icache_types_pkg.sv
rtl/dual_port_bank.sv
rtl/itag_banks.sv
rtl/idata_banks.sv
rtl/icache_request_stage.sv
rtl/icache_fill_ctrl.sv
rtl/icache_response.sv
rtl/icache.sv
dv/tb_clock_gen.sv
dv/icache_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

rm -f sim.log build.log &&
verilator --binary --timing --assert --top-module icache_tb \
    -f icache.f -o icache_sim > build.log 2>&1 ||
{ cat build.log; echo "Build failed"; exit 1; }

./obj_dir/icache_sim > sim.log 2>&1
cat sim.log

grep -qx "PASS: all tests" sim.log && echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- dv/icache_tb.sv
// Instruction cache testbench
`timescale 1ns/1ns
`default_nettype none

module icache_tb;
    import icache_config_pkg::*;
    import icache_types_pkg::*;

    localparam logic [31:0] SEED = 32'hfee5_8926;
    localparam int RESET_CYCLES = 8;
    // Address fields of a byte address
    localparam int SET_LSB = 2 + ICACHE_SUB_LINE_ADDR_W;
    localparam int TAG_LSB = SET_LSB + ICACHE_LINE_ADDR_W;
    // Request counts of the tests
    localparam int COLD_FETCHES = 8;
    localparam int HIT_FETCHES = 32;
    localparam int RANDOM_FETCHES = 200;
    localparam int MAX_REQUESTS = COLD_FETCHES + 4 + HIT_FETCHES + 12 + RANDOM_FETCHES + 9;
    // Worst miss covers detect, request, four gapped beats and the pipeline
    localparam int MISS_CYCLES = 28;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + ICACHE_LINES + 2 + MAX_REQUESTS * MISS_CYCLES;
    // Three lines of one set
    localparam logic [31:0] CONFLICT_LINES [3] = '{32'h0003_0050, 32'h0004_0054, 32'h0005_0058};
    localparam int CONFLICT_SEQ [12] = '{0, 1, 0, 2, 1, 2, 0, 0, 1, 2, 2, 0};

    // Expected response with its due cycle
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] instr;
        logic [31:0] due_cycle;
        logic timed;
    } expected_rsp_t;

    logic clk;
    logic reset;
    logic fetch_req;
    fetch_req_t fetch_req_data;
    logic fetch_ready;
    logic fetch_rsp_valid;
    fetch_rsp_t fetch_rsp;
    logic mem_req;
    mem_req_t mem_req_data;
    logic mem_rsp_valid;
    logic [31:0] mem_rsp_data;

    expected_rsp_t exp_q [$];
    logic [31:0] cycle = '0;
    int mem_req_count = 0;
    // Reference tag model with one round-robin victim
    logic model_valid [ICACHE_WAYS][ICACHE_LINES];
    logic [ICACHE_TAG_W-1:0] model_tag [ICACHE_WAYS][ICACHE_LINES];
    int model_victim = 0;
    int model_misses = 0;
    // Result bookkeeping
    string test_name = "none";
    int tests = 0;
    int checks = 0;
    int errors = 0;
    int test_checks = 0;
    int test_errors = 0;

    tb_clock_gen #(.PERIOD_NS(40)) u_clock (.clk(clk));

    icache u_dut (
        .clk(clk),
        .reset(reset),
        .fetch_req(fetch_req),
        .fetch_req_data(fetch_req_data),
        .fetch_ready(fetch_ready),
        .fetch_rsp_valid(fetch_rsp_valid),
        .fetch_rsp(fetch_rsp),
        .mem_req(mem_req),
        .mem_req_data(mem_req_data),
        .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp_data(mem_rsp_data)
    );

    always @(posedge clk) begin
        cycle <= cycle + 32'd1;
    end

    // Memory contents as a scramble of the whole address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [31:0] line_base_of(input logic [31:0] addr);
        return {addr[31:SET_LSB], {SET_LSB{1'b0}}};
    endfunction

    // Looks up and fills the reference model and returns the hit flag
    function automatic logic model_access(input logic [31:0] addr);
        logic [ICACHE_LINE_ADDR_W-1:0] set_idx;
        logic [ICACHE_TAG_W-1:0] tag;
        set_idx = addr[SET_LSB +: ICACHE_LINE_ADDR_W];
        tag = addr[TAG_LSB +: ICACHE_TAG_W];
        for (int w = 0; w < ICACHE_WAYS; w++) begin
            if (model_valid[w][set_idx] && model_tag[w][set_idx] == tag) begin
                return 1'b1;
            end
        end
        model_valid[model_victim][set_idx] = 1'b1;
        model_tag[model_victim][set_idx] = tag;
        model_victim = (model_victim + 1) % ICACHE_WAYS;
        model_misses++;
        return 1'b0;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        test_checks++;
        assert (actual === expected) else begin
            $display("Error %s: %s expected %h actual %h", test_name, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        test_checks++;
        assert (cond === 1'b1) else begin
            $display("Error %s: %s", test_name, what);
            errors++;
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests++;
        $display("Test %s %s, %0d checks, %0d errors", test_name,
                 (test_errors == 0) ? "ok" : "failed", test_checks, test_errors);
    endtask

    // Drive point of the next cycle with the request strobe dropped
    task automatic next_cycle();
        @(posedge clk);
        #2;
        fetch_req = 1'b0;
    endtask

    // One fetch strobe once the cache is ready
    task automatic issue(input logic [31:0] addr, input logic timed);
        expected_rsp_t entry;
        logic hit;
        while (fetch_ready !== 1'b1) begin
            next_cycle();
        end
        hit = model_access(addr);
        if (timed) begin
            check_true(hit, "warmed line missing from the reference model");
        end
        entry.addr = addr;
        entry.instr = mem_word(addr);
        // Accepted next edge and answered two edges later
        entry.due_cycle = cycle + 32'd3;
        entry.timed = timed;
        exp_q.push_back(entry);
        fetch_req = 1'b1;
        fetch_req_data.addr = addr;
        next_cycle();
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        next_cycle();
    endtask

    // Single fetch that misses or hits as the model says
    task automatic fetch_one(input logic [31:0] addr);
        int reqs_before;
        int misses_before;
        reqs_before = mem_req_count;
        misses_before = model_misses;
        issue(addr, 1'b0);
        drain();
        check_value("mem_req count", model_misses - misses_before, mem_req_count - reqs_before);
    endtask

    // Line fill responder with random beat gaps
    initial begin : memory_model
        logic [31:0] base;
        int gap;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        forever begin
            @(posedge clk);
            #2;
            mem_rsp_valid = 1'b0;
            if (mem_req === 1'b1) begin
                base = mem_req_data.line_addr;
                mem_req_count++;
                // Oldest open fetch is the one in stage 2
                check_true(exp_q.size() != 0, "memory request with no fetch outstanding");
                if (exp_q.size() != 0) begin
                    check_value("mem_req address", line_base_of(exp_q[0].addr), base);
                end
                for (int i = 0; i < ICACHE_LINE_WORDS; i++) begin
                    gap = $urandom_range(3, 0);
                    repeat (gap + 1) begin
                        @(posedge clk);
                        #2;
                        mem_rsp_valid = 1'b0;
                    end
                    mem_rsp_valid = 1'b1;
                    mem_rsp_data = mem_word(base + 32'(i * 4));
                end
            end
        end
    end

    // Responses in request order
    initial begin : response_monitor
        expected_rsp_t entry;
        forever begin
            @(posedge clk);
            #1;
            if (fetch_rsp_valid === 1'b1) begin
                check_true(exp_q.size() != 0, "response with no fetch outstanding");
                if (exp_q.size() != 0) begin
                    entry = exp_q.pop_front();
                    check_value("response address", entry.addr, fetch_rsp.addr);
                    check_value("response word", entry.instr, fetch_rsp.instr);
                    if (entry.timed) begin
                        check_value("response cycle", entry.due_cycle, cycle);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run still busy after %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] addr;
        int reqs_before;
        int misses_before;
        int steps;
        void'($urandom(SEED));
        reset = 1'b1;
        fetch_req = 1'b0;
        fetch_req_data = '0;
        for (int w = 0; w < ICACHE_WAYS; w++) begin
            for (int s = 0; s < ICACHE_LINES; s++) begin
                model_valid[w][s] = 1'b0;
                model_tag[w][s] = '0;
            end
        end

        // Quiet outputs in reset and through the sweep
        start_test("reset");
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            #2;
            check_true(fetch_ready === 1'b0 && fetch_rsp_valid === 1'b0 && mem_req === 1'b0,
                       "output active during reset");
        end
        reset = 1'b0;
        steps = 0;
        while (fetch_ready !== 1'b1 && steps <= ICACHE_LINES + 4) begin
            check_true(fetch_rsp_valid === 1'b0 && mem_req === 1'b0,
                       "output active during the tag sweep");
            next_cycle();
            steps++;
        end
        check_value("cycles to fetch_ready", ICACHE_LINES + 1, steps);
        end_test();

        // Fresh lines in different sets
        start_test("cold_miss");
        reqs_before = mem_req_count;
        for (int i = 0; i < COLD_FETCHES; i++) begin
            fetch_one(32'h0001_0000 + i * 32'h110 + (i % 4) * 4);
        end
        check_value("cold mem_req total", COLD_FETCHES, mem_req_count - reqs_before);
        end_test();

        // Warm four lines and then a burst of hits
        start_test("hit_stream");
        for (int j = 0; j < 4; j++) begin
            fetch_one(32'h0002_0000 + j * 16);
        end
        reqs_before = mem_req_count;
        for (int k = 0; k < HIT_FETCHES; k++) begin
            issue(32'h0002_0000 + ($urandom_range(15, 0) << 2), 1'b1);
        end
        drain();
        check_value("mem_req during hits", 0, mem_req_count - reqs_before);
        end_test();

        // Round-robin victims in one set
        start_test("conflict");
        for (int k = 0; k < 12; k++) begin
            fetch_one(CONFLICT_LINES[CONFLICT_SEQ[k]]);
        end
        end_test();

        // Pipelined random traffic over four tags per set
        start_test("random_mix");
        reqs_before = mem_req_count;
        misses_before = model_misses;
        for (int n = 0; n < RANDOM_FETCHES; n++) begin
            repeat ($urandom_range(2, 0)) next_cycle();
            addr = 32'h0000_8000 + ($urandom_range(255, 0) << 2);
            issue(addr, 1'b0);
        end
        drain();
        check_value("mem_req count", model_misses - misses_before, mem_req_count - reqs_before);
        end_test();

        // Fetch behind a miss in the same line and then a conflicting line
        start_test("stall");
        reqs_before = mem_req_count;
        misses_before = model_misses;
        for (int g = 0; g < 3; g++) begin
            addr = 32'h0006_0000 + g * 32'h20;
            issue(addr + 12, 1'b0);
            // Second fetch enters right behind the miss
            check_true(fetch_ready === 1'b1, "cache not ready for a fetch right behind a miss");
            issue(addr + 4, 1'b0);
            issue(addr + 32'h0100_0000, 1'b0);
            drain();
        end
        check_value("mem_req count", model_misses - misses_before, mem_req_count - reqs_before);
        end_test();

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
// Testbench clock source
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    // Free-running clock, low for the first half period
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- rtl/icache.sv
// Two-way instruction cache
`timescale 1ns/1ns
`default_nettype none

module icache (
    input wire logic clk,
    input wire logic reset,

    input wire logic fetch_req,
    input wire icache_types_pkg::fetch_req_t fetch_req_data,
    output logic fetch_ready,

    output logic fetch_rsp_valid,
    output icache_types_pkg::fetch_rsp_t fetch_rsp,

    output logic mem_req,
    output icache_types_pkg::mem_req_t mem_req_data,
    input wire logic mem_rsp_valid,
    input wire logic [31:0] mem_rsp_data
);
    import icache_config_pkg::*;
    import icache_types_pkg::*;

    // Pipeline stages
    logic stage1_adv;
    logic [31:0] stage1_addr;
    stage_t stage2;
    logic stall;
    logic sweeping;

    // Tag lookup and update
    logic tag_hit;
    logic [ICACHE_WAYS-1:0] tag_hit_way;
    logic update;
    logic [ICACHE_WAYS-1:0] update_way;
    logic [ICACHE_LINE_ADDR_W-1:0] update_line;
    itag_entry_t update_entry;

    // Data fill and readout
    logic fill_we;
    logic [ICACHE_WAYS-1:0] fill_way;
    logic [ICACHE_DATA_ADDR_W-1:0] fill_addr;
    logic [31:0] fill_data;
    logic [31:0] hit_word;
    logic fill_done;
    logic [31:0] fill_word;

    icache_request_stage u_request (.*);

    itag_banks u_itag (
        .*,
        .stage2_addr(stage2.addr)
    );

    idata_banks u_idata (.*);

    icache_fill_ctrl u_fill (.*);

    icache_response u_response (.*);

endmodule

`default_nettype wire

//--- rtl/icache_response.sv
// Fetch response register
`timescale 1ns/1ns
`default_nettype none

module icache_response (
    input wire logic clk,
    input wire logic reset,

    input wire icache_types_pkg::stage_t stage2,
    input wire logic tag_hit,
    input wire logic stall,
    input wire logic [31:0] hit_word,
    input wire logic fill_done,
    input wire logic [31:0] fill_word,

    output logic fetch_rsp_valid,
    output icache_types_pkg::fetch_rsp_t fetch_rsp
);

    logic hit_fire;

    // Bank data is only meaningful while stage 2 moves
    // Fill completion takes priority
    assign hit_fire = stage2.occupied & tag_hit & ~stall & ~fill_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_rsp_valid <= 1'b0;
        end else begin
            fetch_rsp_valid <= hit_fire | fill_done;
        end
    end

    // Address of the answered fetch with its word
    always_ff @(posedge clk) begin
        if (hit_fire | fill_done) begin
            fetch_rsp.addr <= stage2.addr;
            fetch_rsp.instr <= fill_done ? fill_word : hit_word;
        end
    end

endmodule

`default_nettype wire

//--- rtl/icache_fill_ctrl.sv
// Miss and line fill controller
`timescale 1ns/1ns
`default_nettype none

module icache_fill_ctrl (
    input wire logic clk,
    input wire logic reset,

    input wire icache_types_pkg::stage_t stage2,
    input wire logic tag_hit,

    input wire logic mem_rsp_valid,
    input wire logic [31:0] mem_rsp_data,
    output logic mem_req,
    output icache_types_pkg::mem_req_t mem_req_data,

    output logic stall,
    output logic sweeping,

    output logic update,
    output logic [icache_config_pkg::ICACHE_WAYS-1:0] update_way,
    output logic [icache_config_pkg::ICACHE_LINE_ADDR_W-1:0] update_line,
    output icache_types_pkg::itag_entry_t update_entry,

    output logic fill_we,
    output logic [icache_config_pkg::ICACHE_WAYS-1:0] fill_way,
    output logic [icache_config_pkg::ICACHE_DATA_ADDR_W-1:0] fill_addr,
    output logic [31:0] fill_data,
    output logic fill_done,
    output logic [31:0] fill_word
);
    import icache_config_pkg::*;
    import icache_types_pkg::*;

    typedef enum logic [1:0] {SWEEP, IDLE, REQUEST, FILLING} fill_state_t;

    fill_state_t state;
    logic [ICACHE_LINE_ADDR_W-1:0] sweep_line;
    // Beats received for the current line
    logic [ICACHE_SUB_LINE_ADDR_W-1:0] word_cnt;
    // Round-robin victim, one-hot
    logic [ICACHE_WAYS-1:0] victim;
    logic miss;
    logic last_word;

    // Stage 2 left over from a finished fill is not a new miss
    assign miss = (state == IDLE) & stage2.occupied & ~tag_hit & ~fill_done;
    assign last_word = (state == FILLING) & mem_rsp_valid & (&word_cnt);

    assign sweeping = (state == SWEEP);
    assign stall = (state != IDLE) | miss;

    // Single request cycle per miss
    assign mem_req = (state == REQUEST);
    assign mem_req_data = '{line_addr: line_base(stage2.addr)};

    // Beats go straight into the victim way
    assign fill_we = (state == FILLING) & mem_rsp_valid;
    assign fill_way = victim;
    assign fill_addr = {addr_line(stage2.addr), word_cnt};
    assign fill_data = mem_rsp_data;

    // Tag written with the last beat
    always_comb begin
        update = sweeping | last_word;
        update_way = victim;
        update_line = addr_line(stage2.addr);
        update_entry = '{valid: 1'b1, tag: addr_tag(stage2.addr)};
        // sweep clears one set in all ways
        if (sweeping) begin
            update_way = '1;
            update_line = sweep_line;
            update_entry = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= SWEEP;
            sweep_line <= '0;
            word_cnt <= '0;
            victim <= {{(ICACHE_WAYS-1){1'b0}}, 1'b1};
            fill_done <= 1'b0;
        end else begin
            fill_done <= last_word;
            case (state)
                SWEEP: begin
                    sweep_line <= sweep_line + 1'b1;
                    if (&sweep_line) begin
                        state <= IDLE;
                    end
                end
                IDLE: begin
                    if (miss) begin
                        state <= REQUEST;
                    end
                end
                REQUEST: state <= FILLING;
                FILLING: begin
                    // Counter wraps to zero on the last beat
                    if (mem_rsp_valid) begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                    if (last_word) begin
                        state <= IDLE;
                        victim <= {victim[ICACHE_WAYS-2:0], victim[ICACHE_WAYS-1]};
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Keep the beat the stalled fetch asked for
    always_ff @(posedge clk) begin
        if (fill_we && word_cnt == addr_offset(stage2.addr)) begin
            fill_word <= mem_rsp_data;
        end
    end

    // Memory only answers an issued request
    a_rsp_in_fill: assert property (
        @(posedge clk) disable iff (reset) mem_rsp_valid |-> state == FILLING
    );

endmodule

`default_nettype wire

//--- rtl/icache_request_stage.sv
// Fetch request pipeline
`timescale 1ns/1ns
`default_nettype none

module icache_request_stage (
    input wire logic clk,
    input wire logic reset,

    input wire logic fetch_req,
    input wire icache_types_pkg::fetch_req_t fetch_req_data,
    input wire logic stall,
    input wire logic sweeping,
    output logic fetch_ready,

    output logic stage1_adv,
    output logic [31:0] stage1_addr,
    output icache_types_pkg::stage_t stage2
);
    import icache_types_pkg::*;

    stage_t stage1;
    // Front end opens one cycle after the tag sweep
    logic enabled;

    assign fetch_ready = enabled & ~stall;

    // Occupied stage 1 reads the banks every cycle
    // so a fetch held behind a miss sees the filled line
    assign stage1_adv = stage1.occupied;
    assign stage1_addr = stage1.addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            enabled <= 1'b0;
            stage1.occupied <= 1'b0;
            stage2.occupied <= 1'b0;
        end else begin
            enabled <= ~sweeping;
            // Both stages hold while a miss is served
            if (~stall) begin
                stage1.occupied <= fetch_req;
                stage2.occupied <= stage1.occupied;
            end
        end
        // Addresses follow the occupied flags
        if (~stall) begin
            if (fetch_req) begin
                stage1.addr <= fetch_req_data.addr;
            end
            stage2.addr <= stage1.addr;
        end
    end

    // Requester waits for ready
    a_req_when_ready: assert property (
        @(posedge clk) disable iff (reset) fetch_req |-> fetch_ready
    );

endmodule

`default_nettype wire

//--- rtl/idata_banks.sv
// Instruction data banks
`timescale 1ns/1ns
`default_nettype none

module idata_banks (
    input wire logic clk,

    input wire logic [31:0] stage1_addr,
    input wire logic stage1_adv,
    input wire logic [icache_config_pkg::ICACHE_WAYS-1:0] tag_hit_way,

    input wire logic fill_we,
    input wire logic [icache_config_pkg::ICACHE_WAYS-1:0] fill_way,
    input wire logic [icache_config_pkg::ICACHE_DATA_ADDR_W-1:0] fill_addr,
    input wire logic [31:0] fill_data,

    output logic [31:0] hit_word
);
    import icache_config_pkg::*;

    // Word from each way, lined up with stage 2
    logic [31:0] way_word [ICACHE_WAYS];

    for (genvar i = 0; i < ICACHE_WAYS; i++) begin : g_way
        dual_port_bank #(
            .payload_t(logic [31:0]),
            .DEPTH(ICACHE_LINES * ICACHE_LINE_WORDS)
        ) u_bank (
            .clk(clk),
            .read_en(stage1_adv),
            .read_addr(addr_word(stage1_addr)),
            .read_data(way_word[i]),
            .write_en(fill_we & fill_way[i]),
            .write_addr(fill_addr),
            .write_data(fill_data)
        );
    end

    // One-hot select of the hitting way
    // zero when nothing hits
    always_comb begin
        hit_word = '0;
        for (int i = 0; i < ICACHE_WAYS; i++) begin
            if (tag_hit_way[i]) begin
                hit_word = hit_word | way_word[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/itag_banks.sv
// Instruction tag banks
`timescale 1ns/1ns
`default_nettype none

module itag_banks (
    input wire logic clk,

    input wire logic [31:0] stage1_addr,
    input wire logic [31:0] stage2_addr,
    input wire logic stage1_adv,

    input wire logic update,
    input wire logic [icache_config_pkg::ICACHE_WAYS-1:0] update_way,
    input wire logic [icache_config_pkg::ICACHE_LINE_ADDR_W-1:0] update_line,
    input wire icache_types_pkg::itag_entry_t update_entry,

    output logic tag_hit,
    output logic [icache_config_pkg::ICACHE_WAYS-1:0] tag_hit_way
);
    import icache_config_pkg::*;
    import icache_types_pkg::*;

    // Entry of each way for the set read in stage 1
    itag_entry_t tag_line [ICACHE_WAYS];
    // What a valid matching entry looks like
    itag_entry_t stage2_tag;

    assign stage2_tag = '{valid: 1'b1, tag: addr_tag(stage2_addr)};

    for (genvar i = 0; i < ICACHE_WAYS; i++) begin : g_way
        dual_port_bank #(
            .payload_t(itag_entry_t),
            .DEPTH(ICACHE_LINES)
        ) u_bank (
            .clk(clk),
            .read_en(stage1_adv),
            .read_addr(addr_line(stage1_addr)),
            .read_data(tag_line[i]),
            .write_en(update & update_way[i]),
            .write_addr(update_line),
            .write_data(update_entry)
        );

        // Valid flag and tag compared in one go
        assign tag_hit_way[i] = (tag_line[i] == stage2_tag);
    end

    assign tag_hit = |tag_hit_way;

    // Fills only on a miss, so a line never sits in two ways
    a_hit_onehot: assert property (@(posedge clk) $onehot0(tag_hit_way));

endmodule

`default_nettype wire

//--- rtl/dual_port_bank.sv
// Dual-port synchronous bank
`timescale 1ns/1ns
`default_nettype none

module dual_port_bank #(
    parameter type payload_t = logic [31:0],
    parameter int DEPTH = 16
) (
    input wire logic clk,

    input wire logic read_en,
    input wire logic [$clog2(DEPTH)-1:0] read_addr,
    output payload_t read_data,

    input wire logic write_en,
    input wire logic [$clog2(DEPTH)-1:0] write_addr,
    input wire payload_t write_data
);

    payload_t mem [DEPTH];

    // Registered read
    // a same-cycle write to the read address returns the old contents
    always_ff @(posedge clk) begin
        if (read_en) begin
            read_data <= mem[read_addr];
        end
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
    end

    // Drivers upstream keep enabled addresses known
    a_read_addr_known: assert property (
        @(posedge clk) read_en |-> !$isunknown(read_addr)
    );
    a_write_addr_known: assert property (
        @(posedge clk) write_en |-> !$isunknown(write_addr)
    );

endmodule

`default_nettype wire

//--- rtl/icache_types_pkg.sv
// Instruction cache payload types
`default_nettype none

package icache_types_pkg;

    // Valid flag sits above the tag
    typedef struct packed {
        logic valid;
        logic [icache_config_pkg::ICACHE_TAG_W-1:0] tag;
    } itag_entry_t;

    // Fetch request from the front end
    typedef struct packed {
        logic [31:0] addr;
    } fetch_req_t;

    // Returned instruction and the address it came from
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] instr;
    } fetch_rsp_t;

    // One pipeline slot
    typedef struct packed {
        logic [31:0] addr;
        logic occupied;
    } stage_t;

    // Line fill request to memory
    typedef struct packed {
        logic [31:0] line_addr;
    } mem_req_t;

endpackage

`default_nettype wire

//--- rtl/icache_config_pkg.sv
// Instruction cache geometry
`default_nettype none

package icache_config_pkg;

    // Two ways of sixteen lines
    localparam int ICACHE_WAYS = 2;
    localparam int ICACHE_LINES = 16;
    // Four 32-bit words per line
    localparam int ICACHE_LINE_WORDS = 4;

    // Set index and word-in-line widths
    localparam int ICACHE_LINE_ADDR_W = 4;
    localparam int ICACHE_SUB_LINE_ADDR_W = 2;
    // Word index into a data bank
    localparam int ICACHE_DATA_ADDR_W = ICACHE_LINE_ADDR_W + ICACHE_SUB_LINE_ADDR_W;
    // Tag covers bits 31 to 8 above the set
    localparam int ICACHE_TAG_W = 32 - ICACHE_DATA_ADDR_W - 2;

    function automatic logic [ICACHE_TAG_W-1:0] addr_tag(logic [31:0] addr);
        return addr[31 -: ICACHE_TAG_W];
    endfunction

    function automatic logic [ICACHE_LINE_ADDR_W-1:0] addr_line(logic [31:0] addr);
        return addr[ICACHE_DATA_ADDR_W+1 -: ICACHE_LINE_ADDR_W];
    endfunction

    // Word offset within the line
    function automatic logic [ICACHE_SUB_LINE_ADDR_W-1:0] addr_offset(logic [31:0] addr);
        return addr[ICACHE_SUB_LINE_ADDR_W+1:2];
    endfunction

    // Set and offset together
    function automatic logic [ICACHE_DATA_ADDR_W-1:0] addr_word(logic [31:0] addr);
        return addr[ICACHE_DATA_ADDR_W+1:2];
    endfunction

    // First byte of the line
    function automatic logic [31:0] line_base(logic [31:0] addr);
        return {addr[31:ICACHE_SUB_LINE_ADDR_W+2], {(ICACHE_SUB_LINE_ADDR_W+2){1'b0}}};
    endfunction

endpackage

`default_nettype wire
